// File: source/ntm_diff_pkg.sv
`default_nettype none

package ntm_diff_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  parameter int ELEM_W   = 16;
  parameter int DIM_W    = 8;
  parameter int PERIOD_W = 4;
  parameter int CREDIT_W = 4;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  // Matrix element, also used for the modulo
  typedef logic [ELEM_W-1:0]   elem_t;
  // Row/column count or index
  typedef logic [DIM_W-1:0]    dim_t;
  // Differentiation period
  typedef logic [PERIOD_W-1:0] period_t;
  // Output credit count
  typedef logic [CREDIT_W-1:0] credit_t;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    ISSUE
  } diff_state_t;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Configuration taken at start, 36 bits
  typedef struct packed {
    elem_t   modulo;
    dim_t    rows;
    dim_t    cols;
    period_t period;
  } diff_cfg_t;

  // Sequencer to data path, 35 bits
  typedef struct packed {
    elem_t elem;
    elem_t modulo;
    logic  use_prev;
    logic  last_col;
    logic  last_row;
  } diff_issue_t;

  // Output beat, 18 bits
  typedef struct packed {
    elem_t data;
    logic  last_col;
    logic  last_row;
  } diff_beat_t;

endpackage

`default_nettype wire

// File: source/ntm_diff_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_diff_sequencer (
  input  logic                      CLK,
  input  logic                      RST,
  // Start and configuration
  input  logic                      start,
  input  ntm_diff_pkg::diff_cfg_t   cfg,
  // Input element stream
  input  logic                      in_valid,
  input  ntm_diff_pkg::elem_t       in_elem,
  output logic                      in_credit,
  // Free output slot
  input  logic                      has_credit,
  // Issue towards history buffer and subtractor
  output logic                      issue_valid,
  output ntm_diff_pkg::diff_issue_t issue,
  output ntm_diff_pkg::period_t     period
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ntm_diff_pkg::diff_state_t state;

  // Configuration and held beat
  ntm_diff_pkg::diff_cfg_t   cfg_q;
  ntm_diff_pkg::elem_t       elem_q;

  // Matrix loop and vector loop indices
  ntm_diff_pkg::dim_t        row_idx;
  ntm_diff_pkg::dim_t        col_idx;

  logic                      last_col;
  logic                      last_row;

  ////////////////////////////////////////////////////////////
  // Index decode
  ////////////////////////////////////////////////////////////

  // Final column of the current row
  assign last_col = (col_idx == (cfg_q.cols - ntm_diff_pkg::dim_t'(1)));
  // Final row of the matrix
  assign last_row = (row_idx == (cfg_q.rows - ntm_diff_pkg::dim_t'(1)));

  // Issue only with a reserved output slot
  assign issue_valid = (state == ntm_diff_pkg::ISSUE) && has_credit;

  assign issue.elem     = elem_q;
  assign issue.modulo   = cfg_q.modulo;
  // Reference element lies inside the same row
  assign issue.use_prev = (col_idx >= ntm_diff_pkg::dim_t'(cfg_q.period));
  assign issue.last_col = last_col;
  assign issue.last_row = last_row && last_col;

  // Tap select for the history buffer
  assign period = cfg_q.period;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_diff_pkg::IDLE;
      row_idx   <= '0;
      col_idx   <= '0;
      in_credit <= 1'b0;
    end else begin
      // Held beat consumed, give the sender its credit back
      in_credit <= issue_valid;
      case (state)
        ntm_diff_pkg::IDLE: begin
          if (start) begin
            row_idx <= '0;
            col_idx <= '0;
            state   <= ntm_diff_pkg::LOAD;
          end
        end
        ntm_diff_pkg::LOAD: begin
          // Wait for the sender's beat
          if (in_valid) begin
            state <= ntm_diff_pkg::ISSUE;
          end
        end
        ntm_diff_pkg::ISSUE: begin
          // Stall here while no output credit is left
          if (has_credit) begin
            if (last_col) begin
              col_idx <= '0;
              if (last_row) begin
                state <= ntm_diff_pkg::IDLE;
              end else begin
                row_idx <= row_idx + ntm_diff_pkg::dim_t'(1);
                state   <= ntm_diff_pkg::LOAD;
              end
            end else begin
              col_idx <= col_idx + ntm_diff_pkg::dim_t'(1);
              state   <= ntm_diff_pkg::LOAD;
            end
          end
        end
        default: begin
          state <= ntm_diff_pkg::IDLE;
        end
      endcase
    end
  end

  // Config capture at start, element capture in LOAD
  always_ff @(posedge CLK) begin
    if ((state == ntm_diff_pkg::IDLE) && start) begin
      cfg_q <= cfg;
    end
    if ((state == ntm_diff_pkg::LOAD) && in_valid) begin
      elem_q <= in_elem;
    end
  end

endmodule

`default_nettype wire

// File: source/ntm_diff_credit_counter.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_diff_credit_counter #(
  parameter int OUT_CREDITS = 4
) (
  input  logic CLK,
  input  logic RST,
  // Reservation at issue
  input  logic issue_valid,
  // Slot freed by the receiver
  input  logic out_credit,
  output logic has_credit
);

  ////////////////////////////////////////////////////////////
  // Credit count
  ////////////////////////////////////////////////////////////

  ntm_diff_pkg::credit_t count;

  // Receiver starts with all slots free
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      count <= ntm_diff_pkg::credit_t'(OUT_CREDITS);
    end else begin
      case ({issue_valid, out_credit})
        // Issue reserves a slot
        2'b10: begin
          count <= count - ntm_diff_pkg::credit_t'(1);
        end
        // Receiver returned a slot
        2'b01: begin
          count <= count + ntm_diff_pkg::credit_t'(1);
        end
        // Both or neither, count holds
        default: begin
          count <= count;
        end
      endcase
    end
  end

  // Any free slot lets the sequencer issue
  assign has_credit = (count != '0);

endmodule

`default_nettype wire

// File: source/ntm_diff_history_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_diff_history_buffer #(
  parameter int MAX_PERIOD = 8
) (
  input  logic                      CLK,
  input  logic                      RST,
  // Issued element stream
  input  logic                      issue_valid,
  input  ntm_diff_pkg::diff_issue_t issue,
  // Tap select, 1 to MAX_PERIOD
  input  ntm_diff_pkg::period_t     period,
  output ntm_diff_pkg::elem_t       prev
);

  ////////////////////////////////////////////////////////////
  // Shift chain
  ////////////////////////////////////////////////////////////

  // Entry 0 is the most recent issued element
  ntm_diff_pkg::elem_t hist [MAX_PERIOD];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < MAX_PERIOD; i++) begin
        hist[i] <= '0;
      end
    end else if (issue_valid) begin
      hist[0] <= issue.elem;
      for (int i = 1; i < MAX_PERIOD; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Tap select
  ////////////////////////////////////////////////////////////

  // Element period steps back, read before this issue shifts in
  // Out of range period gives zero
  always_comb begin
    prev = '0;
    for (int i = 0; i < MAX_PERIOD; i++) begin
      if (period == ntm_diff_pkg::period_t'(i + 1)) begin
        prev = hist[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/ntm_diff_mod_subtractor.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_diff_mod_subtractor (
  input  logic                      CLK,
  input  logic                      RST,
  // Issue from the sequencer
  input  logic                      issue_valid,
  input  ntm_diff_pkg::diff_issue_t issue,
  // Reference element from the history buffer
  input  ntm_diff_pkg::elem_t       prev,
  // Output beat
  output logic                      out_valid,
  output ntm_diff_pkg::diff_beat_t  out_beat
);

  ////////////////////////////////////////////////////////////
  // Modular difference
  ////////////////////////////////////////////////////////////

  ntm_diff_pkg::elem_t subtrahend;
  ntm_diff_pkg::elem_t raw_diff;
  ntm_diff_pkg::elem_t mod_diff;

  // First period columns of a row pass through
  assign subtrahend = issue.use_prev ? prev : '0;

  assign raw_diff = issue.elem - subtrahend;

  // Negative difference wraps back into range
  // Sum fits since both operands are below the modulo
  assign mod_diff = (issue.elem < subtrahend) ? (raw_diff + issue.modulo) : raw_diff;

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= issue_valid;
    end
  end

  // Beat carries the row flags of its element
  always_ff @(posedge CLK) begin
    if (issue_valid) begin
      out_beat.data     <= mod_diff;
      out_beat.last_col <= issue.last_col;
      out_beat.last_row <= issue.last_row;
    end
  end

endmodule

`default_nettype wire

// File: source/ntm_matrix_differentiation.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_matrix_differentiation #(
  parameter int MAX_PERIOD  = 8,
  parameter int OUT_CREDITS = 4
) (
  input  logic                     CLK,
  input  logic                     RST,
  // Configuration
  input  logic                     start,
  input  ntm_diff_pkg::diff_cfg_t  cfg,
  // Element input, one credit
  input  logic                     in_valid,
  input  ntm_diff_pkg::elem_t      in_elem,
  output logic                     in_credit,
  // Result output, OUT_CREDITS slots
  output logic                     out_valid,
  output ntm_diff_pkg::diff_beat_t out_beat,
  input  logic                     out_credit
);

  ////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////

  logic                      has_credit;
  logic                      issue_valid;
  ntm_diff_pkg::diff_issue_t issue;
  ntm_diff_pkg::period_t     period;
  ntm_diff_pkg::elem_t       prev;

  // Row and column loops, beat hold
  ntm_diff_sequencer sequencer0 (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .cfg         (cfg),
    .in_valid    (in_valid),
    .in_elem     (in_elem),
    .in_credit   (in_credit),
    .has_credit  (has_credit),
    .issue_valid (issue_valid),
    .issue       (issue),
    .period      (period)
  );

  // Output slot tracking
  ntm_diff_credit_counter #(
    .OUT_CREDITS (OUT_CREDITS)
  ) credit_counter0 (
    .CLK         (CLK),
    .RST         (RST),
    .issue_valid (issue_valid),
    .out_credit  (out_credit),
    .has_credit  (has_credit)
  );

  // Past elements of the current row
  ntm_diff_history_buffer #(
    .MAX_PERIOD (MAX_PERIOD)
  ) history_buffer0 (
    .CLK         (CLK),
    .RST         (RST),
    .issue_valid (issue_valid),
    .issue       (issue),
    .period      (period),
    .prev        (prev)
  );

  // Difference and output register
  ntm_diff_mod_subtractor mod_subtractor0 (
    .CLK         (CLK),
    .RST         (RST),
    .issue_valid (issue_valid),
    .issue       (issue),
    .prev        (prev),
    .out_valid   (out_valid),
    .out_beat    (out_beat)
  );

endmodule

`default_nettype wire

// File: verif/tb_ntm_matrix_differentiation.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ntm_matrix_differentiation;

  localparam int MAX_PERIOD  = 8;
  localparam int OUT_CREDITS = 4;
  localparam int HOLD_CYCLES = 40;

  logic                     CLK;
  logic                     RST;
  logic                     start;
  ntm_diff_pkg::diff_cfg_t  cfg;
  logic                     in_valid;
  ntm_diff_pkg::elem_t      in_elem;
  logic                     in_credit;
  logic                     out_valid;
  ntm_diff_pkg::diff_beat_t out_beat;
  logic                     out_credit = 1'b0;

  // Case records from the golden file
  logic [35:0] golden [256];

  int          cycle = 0;
  int          cycle_limit = 1000000;
  int          hold_req = 0;
  int          setup_errors = 0;
  int          main_checks = 0;

  // Receiver state
  int          hold_seen = 0;
  int          hold_left = 0;
  int          free_slots = OUT_CREDITS;
  int          due_q [$];
  logic [31:0] lfsr = 32'hf74d;
  int          rx_base = 0;
  int          rx_case = 0;
  int          rx_k = 0;
  int          rx_n = 0;
  int          rx_total = 0;
  int          rx_checks = 0;
  int          data_errors = 0;
  int          flag_errors = 0;
  int          protocol_errors = 0;

  ntm_matrix_differentiation #(
    .MAX_PERIOD  (MAX_PERIOD),
    .OUT_CREDITS (OUT_CREDITS)
  ) dut0 (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .cfg        (cfg),
    .in_valid   (in_valid),
    .in_elem    (in_elem),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_credit (out_credit)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Run limit from the total element count
  always @(posedge CLK) begin
    cycle = cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("Timeout: cases did not complete within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [35:0] golden_word(input int idx);
    return golden[idx[7:0]];
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Delay of 0 to 7 cycles from 3 random bits
  task automatic random_delay(output int val);
    val = 0;
    for (int b = 0; b < 3; b++) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sender side
  ////////////////////////////////////////////////////////////

  task automatic drive_case(input int base, inout int sent);
    ntm_diff_pkg::diff_cfg_t c;
    logic [35:0]             word;
    int                      n;
    int                      credits;
    c = golden_word(base);
    n = int'(c.rows) * int'(c.cols);
    @(negedge CLK);
    start = 1'b1;
    cfg   = c;
    @(negedge CLK);
    start = 1'b0;
    // One input credit after every start
    credits = 1;
    for (int k = 0; k < n; k++) begin
      while (credits == 0) begin
        @(negedge CLK);
        if (in_credit) credits++;
      end
      word     = golden_word(base + 1 + k);
      in_valid = 1'b1;
      in_elem  = word[15:0];
      credits--;
      @(negedge CLK);
      in_valid = 1'b0;
      if (in_credit) credits++;
    end
    sent = sent + n;
    // All results back before the next start
    while (rx_total != sent) @(posedge CLK);
  endtask

  ////////////////////////////////////////////////////////////
  // Receiver side
  ////////////////////////////////////////////////////////////

  task automatic check_beat();
    ntm_diff_pkg::diff_cfg_t  c;
    ntm_diff_pkg::diff_beat_t exp_beat;
    logic [35:0]              word;
    int                       col;
    int                       delay;
    // Slot accounting against the owned buffer
    free_slots = free_slots - 1;
    if (free_slots < 0) begin
      protocol_errors++;
      $display("Output beat arrived while the receiver had no free slot");
    end
    random_delay(delay);
    due_q.push_back(cycle + delay);
    // Step to the next case once the current one is complete
    if (rx_k == rx_n && rx_n != 0) begin
      rx_base = rx_base + 1 + 2 * rx_n;
      rx_case++;
      rx_k = 0;
    end
    c = golden_word(rx_base);
    rx_n = int'(c.rows) * int'(c.cols);
    if (rx_n == 0) begin
      protocol_errors++;
      $display("Output beat arrived after the last case had completed");
    end else begin
      word = golden_word(rx_base + 1 + rx_n + rx_k);
      col  = rx_k % int'(c.cols);
      exp_beat.data     = word[15:0];
      exp_beat.last_col = (col == int'(c.cols) - 1);
      exp_beat.last_row = exp_beat.last_col && (rx_k == rx_n - 1);
      rx_checks = rx_checks + 2;
      if (out_beat.data !== exp_beat.data) begin
        data_errors++;
        $display("Error case%0d beat %0d: data expected %h actual %h",
                 rx_case, rx_k, exp_beat.data, out_beat.data);
      end
      if ({out_beat.last_col, out_beat.last_row} !== {exp_beat.last_col, exp_beat.last_row}) begin
        flag_errors++;
        $display("Error case%0d beat %0d: last_col/last_row expected %b actual %b",
                 rx_case, rx_k, {exp_beat.last_col, exp_beat.last_row},
                 {out_beat.last_col, out_beat.last_row});
      end
      rx_k++;
    end
    rx_total++;
  endtask

  // One credit back per cycle at most
  task automatic return_credit();
    int idx;
    out_credit = 1'b0;
    if (hold_req != hold_seen) begin
      hold_seen = hold_req;
      hold_left = HOLD_CYCLES;
    end
    if (hold_left > 0) begin
      hold_left--;
    end else begin
      idx = -1;
      for (int i = 0; i < due_q.size(); i++) begin
        if (idx < 0 && due_q[i] <= cycle) idx = i;
      end
      if (idx >= 0) begin
        due_q.delete(idx);
        out_credit = 1'b1;
        free_slots++;
      end
    end
  endtask

  always @(negedge CLK) begin
    if (!RST) begin
      if (out_valid) check_beat();
      return_credit();
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    ntm_diff_pkg::diff_cfg_t c;
    int                      ptr;
    int                      total;
    int                      case_idx;
    int                      sent;
    int                      errors;
    RST      = 1'b1;
    start    = 1'b0;
    cfg      = '0;
    in_valid = 1'b0;
    in_elem  = '0;
    $readmemh("verif/matrix_diff_golden.txt", golden);
    total = 0;
    ptr   = 0;
    while (golden_word(ptr) != 36'h0) begin
      c     = golden_word(ptr);
      total = total + int'(c.rows) * int'(c.cols);
      ptr   = ptr + 1 + 2 * int'(c.rows) * int'(c.cols);
    end
    cycle_limit = 16 * total + 200;

    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Outputs quiet before any start
    repeat (4) begin
      @(negedge CLK);
      main_checks++;
      if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
        setup_errors++;
        $display("out_valid or in_credit went high before the first start");
      end
    end

    ptr      = 0;
    case_idx = 0;
    sent     = 0;
    while (golden_word(ptr) != 36'h0) begin
      @(posedge CLK);
      // Long credit hold on the second case
      if (case_idx == 1) hold_req++;
      drive_case(ptr, sent);
      c        = golden_word(ptr);
      ptr      = ptr + 1 + 2 * int'(c.rows) * int'(c.cols);
      case_idx = case_idx + 1;
    end

    repeat (10) @(posedge CLK);
    main_checks++;
    if (rx_total != total) begin
      setup_errors++;
      $display("Received %0d output beats where %0d were sent", rx_total, total);
    end

    errors = data_errors + flag_errors + protocol_errors + setup_errors;
    $display("Checks %0d, data errors %0d, flag errors %0d, other errors %0d",
             rx_checks + main_checks, data_errors, flag_errors,
             protocol_errors + setup_errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
source/ntm_diff_pkg.sv
source/ntm_diff_sequencer.sv
source/ntm_diff_credit_counter.sv
source/ntm_diff_history_buffer.sv
source/ntm_diff_mod_subtractor.sv
source/ntm_matrix_differentiation.sv
verif/tb_ntm_matrix_differentiation.sv

// File: run.sh
#!/bin/sh
# Compile and run the matrix differentiation testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module tb_ntm_matrix_differentiation \
  -f build.f \
  -o sim_ntm_diff

# Golden file path is relative to the project root
./obj_dir/sim_ntm_diff > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi
echo "Simulation finished without errors"

// File: verif/matrix_diff_golden.txt
// Header per case: modulo[35:20] rows[19:12] cols[11:4] period[3:0]
// Then rows*cols input elements, then rows*cols expected results; zero header ends
// period 1, modulo 17, 2x4
001102041
0003 0008 0002 0010
0005 0005 0000 0009
0003 0005 000b 000e
0005 0000 000c 0009
// period 3, large modulo 65521, 2x6, credits withheld
fff102063
0064 00c8 012c 0032 00fa 0190
0007 fde8 0009 0008 fdf2 0014
0064 00c8 012c ffbf 0032 0064
0007 fde8 0009 0001 000a 000b
// period 2, small modulo 5, 3x3
000503032
0004 0001 0000
0002 0003 0001
0000 0004 0004
0004 0001 0001
0002 0003 0004
0000 0004 0004
// period 8 at full history depth, modulo 256, 1x10
0100010a8
000a 0014 001e 0028 0032 003c 0046 0050 0005 00ff
000a 0014 001e 0028 0032 003c 0046 0050 00fb 00eb
// single element, modulo 7
000701011
0006
0006
// end of cases
000000000
